// ==== common/noc_if_defs.svh ====
/*
 * network interface parameters
 * widths, queue depths, credit limits and flit type codes
 */
`ifndef NOC_IF_DEFS_SVH
`define NOC_IF_DEFS_SVH

`define NOC_PAYLOAD_W   32      // PE word
`define NOC_FLIT_W      64
`define NOC_NODE_W      8       // src/dst node id
`define NOC_ROUTE_DST_W 5       // 5x5 mesh

`define NOC_VC_NUM      4
`define NOC_VC_W        2
`define NOC_CREDIT_MAX  8       // also the VC queue depth
`define NOC_BANK_DEPTH  16      // longest packet
`define NOC_INQ_DEPTH   32
`define NOC_ALLOC_MIN   2       // VC must hold more than this to be picked

// flit type codes
`define NOC_TYPE_HEAD   3'd0
`define NOC_TYPE_BODY   3'd1
`define NOC_TYPE_TAIL   3'd2

`endif

// ==== common/noc_if_pkg.sv ====
/*
 * shared types of the network interface
 * flit layout, router link word, VC index and credit count
 */
`default_nettype none

`include "noc_if_defs.svh"

package noc_if_pkg;

	typedef logic [`NOC_VC_W-1:0] vc_t;
	typedef logic [$clog2(`NOC_CREDIT_MAX+1)-1:0] credit_t;   // 0..8

	// 64 bit flit, msb first
	typedef struct packed {
		logic [2:0]                ftype;
		logic [`NOC_NODE_W-1:0]    src;    // local node id
		logic [`NOC_NODE_W-1:0]    dst;
		logic [3:0]                seq;    // flit index in packet
		logic [8:0]                rsvd;   // {pad, offset, id} on tail, id elsewhere
		logic [`NOC_PAYLOAD_W-1:0] payload;
	} flit_t;

	// 73 bit word on the router link
	typedef struct packed {
		logic                        valid;
		logic                        tail;
		logic [`NOC_ROUTE_DST_W-1:0] rdst;
		vc_t                         vc;
		flit_t                       flit;
	} router_word_t;

endpackage

`default_nettype wire

// ==== common/pkt_buf_if.sv ====
/*
 * packer to scheduler link
 * flit writes into the ping-pong banks, busy flags back
 */
`timescale 1ns/1ps
`default_nettype none

interface pkt_buf_if;
	logic              wr_valid;   // flit write this cycle
	logic              wr_bank;    // target bank
	noc_if_pkg::flit_t wr_flit;
	logic [1:0]        bank_busy;  // bank holds a whole packet not yet sent

	modport packer (output wr_valid, output wr_bank, output wr_flit, input bank_busy);
	modport sched (input wr_valid, input wr_bank, input wr_flit, output bank_busy);
endinterface

`default_nettype wire

// ==== design/sync_fifo.sv ====
/*
 * synchronous FIFO, registered read data
 * data shows the cycle after a read
 */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 64,
	parameter int DEPTH = 16    // power of two
) (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              i_wr_en,
	input  wire [WIDTH-1:0]  i_wr_data,
	input  wire              i_rd_en,
	output logic [WIDTH-1:0] o_rd_data,
	output logic             o_full,
	output logic             o_empty
);

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW:0]      wr_ptr;      // extra bit tells full from empty
	logic [AW:0]      rd_ptr;
	logic             do_wr;
	logic             do_rd;

	assign do_wr   = i_wr_en && !o_full;
	assign do_rd   = i_rd_en && !o_empty;
	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr[AW-1:0]] <= i_wr_data;
		if (do_rd)
			o_rd_data <= mem[rd_ptr[AW-1:0]];   // held until next read
	end

endmodule

`default_nettype wire

// ==== tx/credit_tracker.sv ====
/*
 * per-VC credit counters
 * picks the VC with the most credits, lowest index on a tie
 */
`timescale 1ns/1ps
`default_nettype none

`include "noc_if_defs.svh"

module credit_tracker (
	input  wire                                    clk,
	input  wire                                    rst_n,
	input  wire                                    i_credit_valid,
	input  wire noc_if_pkg::vc_t                   i_credit_vc,
	input  wire                                    i_spend,
	input  wire noc_if_pkg::vc_t                   i_spend_vc,
	output noc_if_pkg::vc_t                        o_best_vc,
	output logic                                   o_best_ok,
	output noc_if_pkg::credit_t [`NOC_VC_NUM-1:0] o_credits
);

	noc_if_pkg::credit_t cnt [`NOC_VC_NUM];
	noc_if_pkg::vc_t     vc_01;
	noc_if_pkg::vc_t     vc_23;

	for (genvar v = 0; v < `NOC_VC_NUM; v++)
	begin : g_cnt
		logic inc;
		logic dec;

		assign inc = i_credit_valid && (i_credit_vc == noc_if_pkg::vc_t'(v));
		assign dec = i_spend && (i_spend_vc == noc_if_pkg::vc_t'(v));

		always_ff @(posedge clk or negedge rst_n)
		begin
			if (!rst_n)
				cnt[v] <= `NOC_CREDIT_MAX;
			else if (inc && !dec)
				cnt[v] <= cnt[v] + 1'b1;
			else if (dec && !inc)
				cnt[v] <= cnt[v] - 1'b1;   // both at once cancel
		end

		assign o_credits[v] = cnt[v];

		// router returns only credits we spent
		a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
			(dec && !inc) |-> (cnt[v] != '0))
			else $error("credit underflow on VC %0d", v);

		a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
			(inc && !dec) |-> (cnt[v] < `NOC_CREDIT_MAX))
			else $error("credit overflow on VC %0d", v);
	end

	// two level compare tree, >= keeps the lower index
	assign vc_01     = (cnt[0] >= cnt[1]) ? 2'd0 : 2'd1;
	assign vc_23     = (cnt[2] >= cnt[3]) ? 2'd2 : 2'd3;
	assign o_best_vc = (cnt[vc_01] >= cnt[vc_23]) ? vc_01 : vc_23;
	assign o_best_ok = cnt[o_best_vc] > `NOC_ALLOC_MIN;

endmodule

`default_nettype wire

// ==== tx/flit_packer.sv ====
/*
 * flit packer
 * PE send handshake, wraps 32 bit words into headed flits
 * and writes the packet into a free buffer bank
 */
`timescale 1ns/1ps
`default_nettype none

`include "noc_if_defs.svh"

module flit_packer (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      i_send_req,
	output logic                     o_send_ack,
	input  wire                      i_data_valid,
	input  wire [`NOC_PAYLOAD_W-1:0] i_data,
	input  wire [`NOC_NODE_W-1:0]    i_dst,
	input  wire [5:0]                i_id,
	input  wire [5:0]                i_seq_len,
	input  wire [`NOC_NODE_W-1:0]    i_local_id,
	pkt_buf_if.packer                pkt_buf
);

	typedef enum logic [1:0] {IDLE, RECV, UPDT, CHEK} state_e;

	state_e                    state;
	logic                      valid_r;    // word registered last cycle
	logic [`NOC_PAYLOAD_W-1:0] data_r;
	logic [3:0]                word_cnt;
	logic [3:0]                seq_r;
	logic [`NOC_NODE_W-1:0]    dst_r;
	logic [5:0]                id_r;
	logic [1:0]                offset_r;   // last byte position
	logic                      sel_bank;
	logic                      first_word;
	logic                      last_flit;
	noc_if_pkg::flit_t         flit;

	assign first_word = i_data_valid && !valid_r;
	assign last_flit  = valid_r && !i_data_valid;   // valid just fell

	// request machine
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= IDLE;
			o_send_ack <= 1'b0;
			sel_bank   <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (i_send_req)
					begin
						state      <= RECV;
						o_send_ack <= 1'b1;
						sel_bank   <= pkt_buf.bank_busy[0];   // bank 0 first
					end
				end
				RECV:
				begin
					if (last_flit)
						state <= UPDT;
				end
				UPDT:
					state <= CHEK;   // busy flag lands this cycle
				CHEK:
				begin
					// hold ack while both banks are full
					if (pkt_buf.bank_busy != 2'b11)
					begin
						state      <= IDLE;
						o_send_ack <= 1'b0;
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid_r  <= 1'b0;
			word_cnt <= '0;
		end
		else
		begin
			valid_r  <= i_data_valid;
			word_cnt <= i_data_valid ? word_cnt + 4'd1 : 4'd0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_data_valid)
		begin
			data_r <= i_data;
			seq_r  <= word_cnt;
		end
		if (first_word)   // header fields come with word 0
		begin
			dst_r    <= i_dst;
			id_r     <= i_id;
			offset_r <= i_seq_len[1:0];
		end
	end

	// flit k goes out one cycle after word k
	always_comb
	begin
		flit.src     = i_local_id;
		flit.dst     = dst_r;
		flit.seq     = seq_r;
		flit.payload = data_r;
		if (seq_r == 4'd0)
		begin
			flit.ftype = `NOC_TYPE_HEAD;   // single word packet stays head
			flit.rsvd  = {3'b000, id_r};
		end
		else if (last_flit)
		begin
			flit.ftype = `NOC_TYPE_TAIL;
			flit.rsvd  = {1'b0, offset_r, id_r};
		end
		else
		begin
			flit.ftype = `NOC_TYPE_BODY;
			flit.rsvd  = {3'b000, id_r};
		end
	end

	assign pkt_buf.wr_valid = valid_r;
	assign pkt_buf.wr_bank  = sel_bank;
	assign pkt_buf.wr_flit  = flit;

	// PE may only start a packet after the ack
	a_data_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(i_data_valid) |-> o_send_ack)
		else $error("data_valid rose without send ack");

	// scheduler still owns a busy bank
	a_no_busy_write: assert property (@(posedge clk) disable iff (!rst_n)
		pkt_buf.wr_valid |-> !pkt_buf.bank_busy[pkt_buf.wr_bank])
		else $error("flit written into busy bank");

endmodule

`default_nettype wire

// ==== tx/tx_link_sched.sv ====
/*
 * transmit link scheduler
 * ping-pong packet banks, VC allocation by credits,
 * one flit per cycle to the router while the VC has credit
 */
`timescale 1ns/1ps
`default_nettype none

`include "noc_if_defs.svh"

module tx_link_sched (
	input  wire                      clk,
	input  wire                      rst_n,
	pkt_buf_if.sched                 pkt_buf,
	input  wire                      i_credit_valid,
	input  wire noc_if_pkg::vc_t     i_credit_vc,
	output noc_if_pkg::router_word_t o_data,
	output logic                     o_data_valid
);

	typedef enum logic [1:0] {S_IDLE, S_ALOC, S_SEND} state_e;

	state_e                                 state;
	logic [1:0]                             busy;
	logic                                   head_bank;   // oldest full bank
	logic                                   cur_bank;    // bank being sent
	logic                                   wr_valid_r;
	logic                                   wr_bank_r;
	logic                                   pkt_done;
	logic                                   sent_last;
	logic [1:0]                             bank_empty;
	noc_if_pkg::flit_t                      bank_data [2];
	logic                                   rd_en;
	logic                                   rd_en_r;
	noc_if_pkg::vc_t                        vc_sel;
	noc_if_pkg::vc_t                        best_vc;
	logic                                   best_ok;
	noc_if_pkg::credit_t [`NOC_VC_NUM-1:0] credits;

	for (genvar b = 0; b < 2; b++)
	begin : g_bank
		sync_fifo #(
			.WIDTH (`NOC_FLIT_W),
			.DEPTH (`NOC_BANK_DEPTH)
		) u_bank (
			.clk       (clk),
			.rst_n     (rst_n),
			.i_wr_en   (pkt_buf.wr_valid && (pkt_buf.wr_bank == 1'(b))),
			.i_wr_data (pkt_buf.wr_flit),
			.i_rd_en   (rd_en && (cur_bank == 1'(b))),
			.o_rd_data (bank_data[b]),
			.o_full    (),
			.o_empty   (bank_empty[b])
		);
	end

	credit_tracker u_credit (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_credit_valid (i_credit_valid),
		.i_credit_vc    (i_credit_vc),
		.i_spend        (rd_en),
		.i_spend_vc     (vc_sel),
		.o_best_vc      (best_vc),
		.o_best_ok      (best_ok),
		.o_credits      (credits)
	);

	assign pkt_done  = wr_valid_r && !pkt_buf.wr_valid;      // packer write burst ended
	assign sent_last = rd_en_r && bank_empty[cur_bank];      // word on link drained the bank

	// bank ownership, head tracks packet order
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy       <= 2'b00;
			head_bank  <= 1'b0;
			wr_valid_r <= 1'b0;
			wr_bank_r  <= 1'b0;
		end
		else
		begin
			wr_valid_r <= pkt_buf.wr_valid;
			wr_bank_r  <= pkt_buf.wr_bank;
			if (pkt_done)
				busy[wr_bank_r] <= 1'b1;
			if (sent_last)
				busy[cur_bank] <= 1'b0;
			if (sent_last)
				head_bank <= !cur_bank;   // other bank is next, if filled
			else if (pkt_done && (busy == 2'b00))
				head_bank <= wr_bank_r;
		end
	end

	// idle / allocate / send
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= S_IDLE;
			cur_bank <= 1'b0;
			vc_sel   <= '0;
			rd_en_r  <= 1'b0;
		end
		else
		begin
			rd_en_r <= rd_en;
			case (state)
				S_IDLE:
				begin
					if (busy[head_bank])
					begin
						cur_bank <= head_bank;
						state    <= S_ALOC;
					end
				end
				S_ALOC:
				begin
					if (best_ok)   // wait for a VC above the minimum
					begin
						vc_sel <= best_vc;
						state  <= S_SEND;
					end
				end
				S_SEND:
				begin
					if (sent_last)
						state <= S_IDLE;
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// stall at zero credit, whole packet on vc_sel
	assign rd_en = (state == S_SEND) && !bank_empty[cur_bank] && (credits[vc_sel] != '0);

	always_comb
	begin
		o_data.valid = rd_en_r;
		o_data.tail  = sent_last;
		o_data.rdst  = bank_data[cur_bank].dst[`NOC_ROUTE_DST_W-1:0];
		o_data.vc    = vc_sel;
		o_data.flit  = bank_data[cur_bank];
	end

	assign o_data_valid      = rd_en_r;
	assign pkt_buf.bank_busy = busy;

endmodule

`default_nettype wire

// ==== rx/rx_vc_drain.sv ====
/*
 * receive path
 * four VC queues drained round-robin into the input queue,
 * credit return per flit and PE req/ack read
 */
`timescale 1ns/1ps
`default_nettype none

`include "noc_if_defs.svh"

module rx_vc_drain (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire noc_if_pkg::router_word_t i_flit,
	output logic                          o_credit_valid,
	output noc_if_pkg::vc_t               o_credit_vc,
	output logic                          o_req_rx,
	input  wire                           i_ack_rx,
	output noc_if_pkg::flit_t             o_data_input,
	output logic                          o_data_input_valid
);

	logic [`NOC_VC_NUM-1:0]   vcq_wr;
	logic [`NOC_VC_NUM-1:0]   vcq_rd;
	logic [`NOC_VC_NUM-1:0]   vcq_full;
	logic [`NOC_VC_NUM-1:0]   vcq_empty;
	noc_if_pkg::router_word_t vcq_data [`NOC_VC_NUM];
	noc_if_pkg::vc_t          last_vc;    // last queue served
	noc_if_pkg::vc_t          pick_vc;
	noc_if_pkg::vc_t          fwd_vc;     // queue read last cycle
	noc_if_pkg::vc_t          idx;
	logic                     pick_ok;
	logic                     visit;
	logic                     fwd_r;
	logic                     inq_full;
	logic                     inq_empty;

	for (genvar v = 0; v < `NOC_VC_NUM; v++)
	begin : g_vcq
		assign vcq_wr[v] = i_flit.valid && (i_flit.vc == noc_if_pkg::vc_t'(v));
		assign vcq_rd[v] = visit && (pick_vc == noc_if_pkg::vc_t'(v));

		sync_fifo #(
			.WIDTH ($bits(noc_if_pkg::router_word_t)),
			.DEPTH (`NOC_CREDIT_MAX)
		) u_vcq (
			.clk       (clk),
			.rst_n     (rst_n),
			.i_wr_en   (vcq_wr[v]),
			.i_wr_data (i_flit),
			.i_rd_en   (vcq_rd[v]),
			.o_rd_data (vcq_data[v]),
			.o_full    (vcq_full[v]),
			.o_empty   (vcq_empty[v])
		);
	end

	// round-robin, search starts after last_vc
	always_comb
	begin
		pick_vc = last_vc;
		pick_ok = 1'b0;
		idx     = last_vc;
		for (int k = 1; k <= `NOC_VC_NUM; k++)
		begin
			idx = last_vc + noc_if_pkg::vc_t'(k);   // wraps mod 4
			if (!pick_ok && !vcq_empty[idx])
			begin
				pick_vc = idx;
				pick_ok = 1'b1;
			end
		end
	end

	// one visit every other cycle so inq full is current
	assign visit = pick_ok && !fwd_r && !inq_full;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			last_vc <= '0;
			fwd_vc  <= '0;
			fwd_r   <= 1'b0;
		end
		else
		begin
			fwd_r <= visit;
			if (visit)
			begin
				last_vc <= pick_vc;
				fwd_vc  <= pick_vc;
			end
		end
	end

	sync_fifo #(
		.WIDTH (`NOC_FLIT_W),
		.DEPTH (`NOC_INQ_DEPTH)
	) u_inq (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_wr_en   (fwd_r),
		.i_wr_data (vcq_data[fwd_vc].flit),
		.i_rd_en   (i_ack_rx),
		.o_rd_data (o_data_input),
		.o_full    (inq_full),
		.o_empty   (inq_empty)
	);

	assign o_credit_valid = fwd_r;    // one credit per forwarded flit
	assign o_credit_vc    = fwd_vc;

	// PE side, req drops for a cycle after every ack
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			o_req_rx           <= 1'b0;
			o_data_input_valid <= 1'b0;
		end
		else
		begin
			o_req_rx           <= !inq_empty && !i_ack_rx;
			o_data_input_valid <= i_ack_rx;   // head entry shows next cycle
		end
	end

	// router keeps within the credits it was given
	a_vcq_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		i_flit.valid |-> !vcq_full[i_flit.vc])
		else $error("flit into full VC queue");

	a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		i_ack_rx |-> o_req_rx)
		else $error("ack_rx without req_rx");

endmodule

`default_nettype wire

// ==== design/noc_if_top.sv ====
/*
 * PE to mesh router network interface
 * transmit packer and scheduler, receive VC drain
 */
`timescale 1ns/1ps
`default_nettype none

`include "noc_if_defs.svh"

module noc_if_top (
	input  wire                           clk,
	input  wire                           rst_n,
	// PE transmit
	input  wire                           i_send_req,
	output logic                          o_send_ack,
	input  wire                           i_data_valid,
	input  wire [`NOC_PAYLOAD_W-1:0]      i_data,
	input  wire [`NOC_NODE_W-1:0]         i_dst,
	input  wire [5:0]                     i_id,
	input  wire [5:0]                     i_seq_len,
	// PE receive
	output logic                          o_req_rx,
	input  wire                           i_ack_rx,
	output noc_if_pkg::flit_t             o_data_input,
	output logic                          o_data_input_valid,
	// router link
	output noc_if_pkg::router_word_t      o_data,
	output logic                          o_data_valid,
	input  wire noc_if_pkg::router_word_t i_flit,
	input  wire                           i_credit_valid,
	input  wire noc_if_pkg::vc_t          i_credit_vc,
	output logic                          o_credit_valid,
	output noc_if_pkg::vc_t               o_credit_vc,
	// tag
	input  wire [`NOC_NODE_W-1:0]         i_local_id
);

	pkt_buf_if pkt_buf ();

	flit_packer u_packer (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_send_req   (i_send_req),
		.o_send_ack   (o_send_ack),
		.i_data_valid (i_data_valid),
		.i_data       (i_data),
		.i_dst        (i_dst),
		.i_id         (i_id),
		.i_seq_len    (i_seq_len),
		.i_local_id   (i_local_id),
		.pkt_buf      (pkt_buf.packer)
	);

	tx_link_sched u_sched (
		.clk            (clk),
		.rst_n          (rst_n),
		.pkt_buf        (pkt_buf.sched),
		.i_credit_valid (i_credit_valid),
		.i_credit_vc    (i_credit_vc),
		.o_data         (o_data),
		.o_data_valid   (o_data_valid)
	);

	rx_vc_drain u_rx (
		.clk                (clk),
		.rst_n              (rst_n),
		.i_flit             (i_flit),
		.o_credit_valid     (o_credit_valid),
		.o_credit_vc        (o_credit_vc),
		.o_req_rx           (o_req_rx),
		.i_ack_rx           (i_ack_rx),
		.o_data_input       (o_data_input),
		.o_data_input_valid (o_data_input_valid)
	);

endmodule

`default_nettype wire

// ==== verif/noc_if_tb.sv ====
/*
 * network interface testbench
 * table driven tx packets and rx flits against a credit and flit model
 */
`timescale 1ns/1ps
`default_nettype none

`include "noc_if_defs.svh"

module noc_if_tb;

	localparam int TX_ROWS = 10;
	localparam int RX_ROWS = 12;
	localparam int TIMEOUT = 40 * (TX_ROWS + RX_ROWS) + 200;   // cycles
	localparam logic [7:0] LOCAL_ID = 8'h2a;

	// credit handling after a tx row
	localparam int P_DRAIN  = 0;   // wait for the packet, free a stall first
	localparam int P_REFILL = 1;   // drain, then top every VC back up
	localparam int P_QUEUE  = 2;   // next row goes out while this one is in flight
	localparam int P_HOLD   = 3;   // both banks full, ack must hold

	typedef struct {
		int         len;
		logic [7:0] dst;
		logic [5:0] id;
		logic [5:0] seq_len;
		int         pol;
	} tx_row_t;

	typedef struct {
		noc_if_pkg::vc_t   vc;
		noc_if_pkg::flit_t flit;
	} rx_row_t;

	logic                     clk;
	logic                     rst_n;
	logic                     i_send_req;
	logic                     o_send_ack;
	logic                     i_data_valid;
	logic [31:0]              i_data;
	logic [7:0]               i_dst;
	logic [5:0]               i_id;
	logic [5:0]               i_seq_len;
	logic                     o_req_rx;
	logic                     i_ack_rx;
	noc_if_pkg::flit_t        o_data_input;
	logic                     o_data_input_valid;
	noc_if_pkg::router_word_t o_data;
	logic                     o_data_valid;
	noc_if_pkg::router_word_t i_flit;
	logic                     i_credit_valid;
	noc_if_pkg::vc_t          i_credit_vc;
	logic                     o_credit_valid;
	noc_if_pkg::vc_t          o_credit_vc;
	logic [7:0]               i_local_id;

	tx_row_t                  tx_tab [TX_ROWS];
	rx_row_t                  rx_tab [RX_ROWS];
	bit                       rx_used [RX_ROWS];   // delivered to the PE
	noc_if_pkg::router_word_t exp_q [$];           // router words still to come
	noc_if_pkg::router_word_t mon_exp;
	noc_if_pkg::vc_t          cred_q [$];          // credit returns in order
	int                       model_cr [`NOC_VC_NUM];
	noc_if_pkg::vc_t          pend_vc;             // VC of a stalled packet
	int                       pend_cnt;            // flits it still lacks credit for
	int                       got_cnt;
	int                       exp_cnt;
	int                       cycles;
	int                       errors;
	int                       err_base;
	int                       tests;
	int                       fails;
	int                       seed_val;

	noc_if_top dut (
		.clk                (clk),
		.rst_n              (rst_n),
		.i_send_req         (i_send_req),
		.o_send_ack         (o_send_ack),
		.i_data_valid       (i_data_valid),
		.i_data             (i_data),
		.i_dst              (i_dst),
		.i_id               (i_id),
		.i_seq_len          (i_seq_len),
		.o_req_rx           (o_req_rx),
		.i_ack_rx           (i_ack_rx),
		.o_data_input       (o_data_input),
		.o_data_input_valid (o_data_input_valid),
		.o_data             (o_data),
		.o_data_valid       (o_data_valid),
		.i_flit             (i_flit),
		.i_credit_valid     (i_credit_valid),
		.i_credit_vc        (i_credit_vc),
		.o_credit_valid     (o_credit_valid),
		.o_credit_vc        (o_credit_vc),
		.i_local_id         (i_local_id)
	);

	always #20 clk = ~clk;   // 40 ns period

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT)
		begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// router side and credit monitor, sampled mid cycle
	always @(negedge clk)
	begin
		if (rst_n && o_data_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("router word at %0t while no packet was waiting to go out", $time);
				errors++;
			end
			else
			begin
				mon_exp = exp_q.pop_front();
				check_router_word("o_data", o_data, mon_exp);
			end
			got_cnt++;
		end
		if (rst_n && o_credit_valid)
			cred_q.push_back(o_credit_vc);
	end

	task automatic tick();
		@(posedge clk);
		#2;   // inputs change just after the edge
	endtask

	task automatic check_router_word(input string name, input noc_if_pkg::router_word_t got,
		input noc_if_pkg::router_word_t exp);
		if (got !== exp)
		begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flit(input string name, input noc_if_pkg::flit_t got,
		input noc_if_pkg::flit_t exp);
		if (got !== exp)
		begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_vc(input string name, input noc_if_pkg::vc_t got,
		input noc_if_pkg::vc_t exp);
		if (got !== exp)
		begin
			$display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == err_base)
			$display("%-22s ok", name);
		else
		begin
			fails++;
			$display("%-22s FAILED with %0d errors", name, errors - err_base);
		end
		err_base = errors;
	endtask

	// most credits wins, strict compare keeps the lowest index on a tie
	function automatic int best_vc();
		int best;
		best = 0;
		for (int v = 1; v < `NOC_VC_NUM; v++)
			if (model_cr[v] > model_cr[best])
				best = v;
		return best;
	endfunction

	task automatic return_credits(input noc_if_pkg::vc_t vc, input int n);
		for (int k = 0; k < n; k++)
		begin
			i_credit_valid = 1'b1;
			i_credit_vc    = vc;
			tick();
		end
		i_credit_valid = 1'b0;
	endtask

	task automatic send_packet(input tx_row_t r);
		int                       vc;
		int                       avail;
		logic [31:0]              word;
		noc_if_pkg::router_word_t w;
		while (o_send_ack)   // previous packet not released yet
			tick();
		vc    = best_vc();
		avail = model_cr[vc];
		if (r.len > avail)
		begin
			pend_vc  = noc_if_pkg::vc_t'(vc);
			pend_cnt = r.len - avail;
		end
		model_cr[vc] = (r.len > avail) ? 0 : avail - r.len;   // shortfall comes back mid packet
		i_send_req = 1'b1;
		tick();
		i_send_req = 1'b0;
		while (!o_send_ack)
			tick();
		for (int k = 0; k < r.len; k++)
		begin
			word            = $urandom();
			w.valid         = 1'b1;
			w.tail          = (k == r.len - 1);
			w.rdst          = r.dst[4:0];
			w.vc            = noc_if_pkg::vc_t'(vc);
			w.flit.src      = LOCAL_ID;
			w.flit.dst      = r.dst;
			w.flit.seq      = 4'(k);
			w.flit.payload  = word;
			w.flit.rsvd     = {3'b000, r.id};
			if (k == 0)
				w.flit.ftype = `NOC_TYPE_HEAD;
			else if (k == r.len - 1)
			begin
				w.flit.ftype = `NOC_TYPE_TAIL;
				w.flit.rsvd  = {1'b0, r.seq_len[1:0], r.id};   // offset ahead of id
			end
			else
				w.flit.ftype = `NOC_TYPE_BODY;
			exp_q.push_back(w);
			exp_cnt++;
			i_data_valid = 1'b1;
			i_data       = word;
			i_dst        = (k == 0) ? r.dst : ~r.dst;   // header only valid on word 0
			i_id         = (k == 0) ? r.id : ~r.id;
			i_seq_len    = (k == 0) ? r.seq_len : ~r.seq_len;
			tick();
		end
		i_data_valid = 1'b0;
	endtask

	task automatic finish_row(input int pol);
		int target;
		case (pol)
			P_DRAIN, P_REFILL:
			begin
				target = exp_cnt - pend_cnt;   // where a stalled VC runs dry
				while (got_cnt < target)
					tick();
				if (pend_cnt > 0)
				begin
					repeat (4)
						tick();
					check_bit("o_data_valid", o_data_valid, 1'b0);
					if (got_cnt != target)
					begin
						$display("router took %0d flits past the credit limit", got_cnt - target);
						errors++;
					end
					return_credits(pend_vc, pend_cnt);
					pend_cnt = 0;
				end
				while (got_cnt < exp_cnt)
					tick();
				if (pol == P_REFILL)
				begin
					for (int v = 0; v < `NOC_VC_NUM; v++)
					begin
						return_credits(noc_if_pkg::vc_t'(v), `NOC_CREDIT_MAX - model_cr[v]);
						model_cr[v] = `NOC_CREDIT_MAX;
					end
				end
			end
			P_HOLD:
			begin
				repeat (8)
				begin
					tick();
					check_bit("o_send_ack", o_send_ack, 1'b1);   // both banks still full
				end
				return_credits(pend_vc, pend_cnt);
				pend_cnt = 0;
				while (o_send_ack)
					tick();
			end
			default:
				tick();
		endcase
	endtask

	// find which VC the flit came in on, then demand the oldest one of that VC
	task automatic match_rx(input noc_if_pkg::flit_t got, input int idx);
		int src_row;
		int exp_row;
		src_row = -1;
		exp_row = -1;
		for (int j = 0; j < RX_ROWS; j++)
			if (src_row < 0 && !rx_used[j] && rx_tab[j].flit == got)
				src_row = j;
		if (src_row < 0)
		begin
			$display("o_data_input at %0t holds a flit never sent or sent twice", $time);
			errors++;
		end
		else
		begin
			for (int j = 0; j < RX_ROWS; j++)
				if (exp_row < 0 && !rx_used[j] && rx_tab[j].vc == rx_tab[src_row].vc)
					exp_row = j;
			check_flit("o_data_input", got, rx_tab[exp_row].flit);
			rx_used[exp_row] = 1'b1;
			if (idx < cred_q.size())
				check_vc("o_credit_vc", cred_q[idx], rx_tab[src_row].vc);
		end
	endtask

	task automatic load_tables();
		// len, dst, id, seq_len, credit policy
		tx_tab[0] = '{4, 8'h13, 6'h05, 6'd13, P_DRAIN};
		tx_tab[1] = '{5, 8'h27, 6'h11, 6'd18, P_DRAIN};
		tx_tab[2] = '{6, 8'h08, 6'h22, 6'd23, P_DRAIN};
		tx_tab[3] = '{3, 8'h3e, 6'h3f, 6'd11, P_DRAIN};
		tx_tab[4] = '{1, 8'h15, 6'h01, 6'd4, P_DRAIN};
		tx_tab[5] = '{16, 8'h0c, 6'h2c, 6'd63, P_REFILL};  // stalls on VC0
		tx_tab[6] = '{16, 8'h11, 6'h07, 6'd62, P_QUEUE};   // stalls, left in bank 0
		tx_tab[7] = '{5, 8'h1f, 6'h19, 6'd17, P_HOLD};     // fills bank 1
		tx_tab[8] = '{7, 8'h04, 6'h30, 6'd26, P_REFILL};
		tx_tab[9] = '{2, 8'hf6, 6'h0a, 6'd6, P_DRAIN};
		// vc, flit
		rx_tab[0]  = '{2'd1, noc_if_pkg::flit_t'(64'h2000_0100_0000_1001)};
		rx_tab[1]  = '{2'd1, noc_if_pkg::flit_t'(64'h2000_0110_0000_1002)};
		rx_tab[2]  = '{2'd3, noc_if_pkg::flit_t'(64'h0300_0200_0000_3001)};
		rx_tab[3]  = '{2'd0, noc_if_pkg::flit_t'(64'h0000_4000_0000_0001)};
		rx_tab[4]  = '{2'd2, noc_if_pkg::flit_t'(64'h1122_0000_0000_2001)};
		rx_tab[5]  = '{2'd1, noc_if_pkg::flit_t'(64'h2000_0120_0000_1003)};
		rx_tab[6]  = '{2'd0, noc_if_pkg::flit_t'(64'h0000_4010_0000_0002)};
		rx_tab[7]  = '{2'd3, noc_if_pkg::flit_t'(64'h0300_0210_0000_3002)};
		rx_tab[8]  = '{2'd3, noc_if_pkg::flit_t'(64'h0300_0220_0000_3003)};
		rx_tab[9]  = '{2'd2, noc_if_pkg::flit_t'(64'h1122_0010_0000_2002)};
		rx_tab[10] = '{2'd1, noc_if_pkg::flit_t'(64'h2000_0130_0000_1004)};
		rx_tab[11] = '{2'd0, noc_if_pkg::flit_t'(64'h0000_4020_0000_0003)};
	endtask

	initial
	begin
		clk            = 1'b0;
		rst_n          = 1'b0;
		i_send_req     = 1'b0;
		i_data_valid   = 1'b0;
		i_data         = '0;
		i_dst          = '0;
		i_id           = '0;
		i_seq_len      = '0;
		i_ack_rx       = 1'b0;
		i_flit         = '0;
		i_credit_valid = 1'b0;
		i_credit_vc    = '0;
		i_local_id     = LOCAL_ID;
		cycles         = 0;
		errors         = 0;
		err_base       = 0;
		tests          = 0;
		fails          = 0;
		got_cnt        = 0;
		exp_cnt        = 0;
		pend_cnt       = 0;
		pend_vc        = '0;
		seed_val       = $urandom(32'h6fd9);
		for (int v = 0; v < `NOC_VC_NUM; v++)
			model_cr[v] = `NOC_CREDIT_MAX;
		for (int j = 0; j < RX_ROWS; j++)
			rx_used[j] = 1'b0;
		load_tables();

		repeat (8)
			@(posedge clk);
		#2;
		rst_n = 1'b1;
		check_bit("o_send_ack", o_send_ack, 1'b0);
		check_bit("o_data_valid", o_data_valid, 1'b0);
		check_bit("o_credit_valid", o_credit_valid, 1'b0);
		check_bit("o_data_input_valid", o_data_input_valid, 1'b0);
		repeat (5)
		begin
			check_bit("o_req_rx", o_req_rx, 1'b0);   // nothing received yet
			tick();
		end
		end_test("reset");

		for (int i = 0; i < TX_ROWS; i++)
		begin
			send_packet(tx_tab[i]);
			finish_row(tx_tab[i].pol);
			end_test($sformatf("tx row %0d", i));
		end
		if (exp_q.size() != 0)
		begin
			$display("%0d router words never came out", exp_q.size());
			errors++;
		end
		end_test("tx all flits out");

		// rx flits back to back, VC queues drain on their own
		for (int i = 0; i < RX_ROWS; i++)
		begin
			i_flit       = '0;
			i_flit.valid = 1'b1;
			i_flit.vc    = rx_tab[i].vc;
			i_flit.flit  = rx_tab[i].flit;
			tick();
		end
		i_flit = '0;
		while (cred_q.size() < RX_ROWS)
			tick();
		repeat (4)
			tick();
		if (cred_q.size() != RX_ROWS)
		begin
			$display("%0d credit returns for %0d received flits", cred_q.size(), RX_ROWS);
			errors++;
		end
		end_test("rx vc drain");

		for (int i = 0; i < RX_ROWS; i++)
		begin
			while (!o_req_rx)
				tick();
			check_bit("o_data_input_valid", o_data_input_valid, 1'b0);
			i_ack_rx = 1'b1;
			tick();
			i_ack_rx = 1'b0;
			check_bit("o_data_input_valid", o_data_input_valid, 1'b1);   // one cycle after ack
			match_rx(o_data_input, i);
		end
		repeat (3)
			tick();
		check_bit("o_req_rx", o_req_rx, 1'b0);   // input queue drained
		end_test("rx pe read");

		$display("summary: %0d tests, %0d failed, %0d errors", tests, fails, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== noc_if_top.f ====
+incdir+common
common/noc_if_pkg.sv
common/pkt_buf_if.sv
design/sync_fifo.sv
tx/credit_tracker.sv
tx/flit_packer.sv
tx/tx_link_sched.sv
rx/rx_vc_drain.sv
design/noc_if_top.sv
verif/noc_if_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the network interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f noc_if_top.f --top-module noc_if_tb --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vnoc_if_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
	exit 1
fi
exit 0
